//--- list.f
rtl/core_pkg.sv
rtl/core_setting_regs.sv
rtl/pps_source.sv
rtl/core_readback.sv
rtl/core_control.sv
sim/core_control_assertions.sv
sim/tb_core_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core_control \
    -f list.f -o tb_core_control &&
./obj_dir/tb_core_control | tee /dev/stderr | grep -q "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- sim/tb_core_control.sv
/*
 * Testbench for core_control with a 20-cycle internal PPS period.
 * Table entries run in order and share the register state left by earlier ones.
 */
`timescale 1ns/10ps

module tb_core_control;

    import core_pkg::*;

    localparam int K_RESET = 0;    // check reset values only
    localparam int K_WRITE = 1;    // plain register write
    localparam int K_MISC  = 2;    // write, then misc and unchanged outputs
    localparam int K_RB    = 3;    // status inputs, slot select, readback
    localparam int K_SYNC  = 4;    // sync word write, time-sync level
    localparam int K_PULSE = 5;    // pulse on a pps input, latency to o_pps
    localparam int K_COUNT = 6;    // high cycles of o_pps over one period
    localparam int N_MAX   = 32;
    localparam int TIMEOUT = 16;

    logic       radio_clk = 1'b0;
    logic       bus_rst;
    logic       set_stb;
    set_addr_t  set_addr;
    set_data_t  set_data;
    set_data_t  rb_misc;
    logic [1:0] lock_signals;
    logic       pps_int;
    logic       pps_ext;
    set_data_t  misc_outs;
    rb_data_t   rb_data;
    logic       pps;
    logic       time_sync;

    // stimulus table columns
    int         kind [N_MAX];
    set_addr_t  addr [N_MAX];
    set_data_t  data [N_MAX];
    set_data_t  misc_in [N_MAX];
    logic [1:0] lock_in [N_MAX];
    rb_data_t   exp_val [N_MAX];
    string      note [N_MAX];
    int         n_entries = 0;
    int         seed = 13;
    int         errors = 0;

    always #2 radio_clk = ~radio_clk;

    core_control #(
        .PPS_PERIOD (20)
    ) core_control_i (
        .i_clk          (radio_clk),
        .i_rst          (bus_rst),
        .i_set_stb      (set_stb),
        .i_set_addr     (set_addr),
        .i_set_data     (set_data),
        .i_rb_misc      (rb_misc),
        .i_lock_signals (lock_signals),
        .i_pps_int      (pps_int),
        .i_pps_ext      (pps_ext),
        .o_misc_outs    (misc_outs),
        .o_rb_data      (rb_data),
        .o_pps          (pps),
        .o_time_sync    (time_sync)
    );

    task automatic add_entry(input int k, input set_addr_t a, input set_data_t d,
                             input set_data_t m, input logic [1:0] l,
                             input rb_data_t e, input string s);
        kind[n_entries]    = k;
        addr[n_entries]    = a;
        data[n_entries]    = d;
        misc_in[n_entries] = m;
        lock_in[n_entries] = l;
        exp_val[n_entries] = e;
        note[n_entries]    = s;
        n_entries++;
    endtask

    task automatic check_rb(input string name, input rb_data_t exp, input rb_data_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input set_data_t exp, input set_data_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // one strobe; returns at the falling edge after the register has loaded
    task automatic bus_write(input set_addr_t a, input set_data_t d);
        @(posedge radio_clk);
        set_stb  <= 1'b1;
        set_addr <= a;
        set_data <= d;
        @(posedge radio_clk);
        set_stb  <= 1'b0;
        @(negedge radio_clk);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge radio_clk);
        end
    endtask

    // unselected input first, then the selected one, one cycle high each
    task automatic pulse_latency(input logic use_ext, output int lat);
        lat = 0;
        @(posedge radio_clk);
        pps_int <= use_ext;
        pps_ext <= !use_ext;
        @(posedge radio_clk);
        pps_int <= 1'b0;
        pps_ext <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge radio_clk);
            check_bit("o_pps", 1'b0, pps);
        end
        @(posedge radio_clk);
        pps_int <= !use_ext;
        pps_ext <= use_ext;
        @(negedge radio_clk);
        while (!pps && lat < TIMEOUT) begin
            @(posedge radio_clk);
            lat++;
            pps_int <= 1'b0;
            pps_ext <= 1'b0;
            @(negedge radio_clk);
        end
        if (!pps) begin
            $display("o_pps never went high after the pulse on the selected input");
            errors++;
        end
    endtask

    task automatic count_high(output int n);
        n = 0;
        // select settles for three cycles first
        idle_cycles(3);
        for (int i = 0; i < 20; i++) begin
            @(negedge radio_clk);
            if (pps) begin
                n++;
            end
        end
    endtask

    task automatic build_table();
        set_data_t w0;
        set_data_t w1;
        set_data_t m;
        rb_data_t  compat;
        compat = {32'hACE0_BA5E, 16'h000E, 16'h0000};
        w0 = $random(seed);
        w1 = $random(seed);
        m  = $random(seed);
        add_entry(K_RESET, 8'd0,  32'd0, 32'd0, 2'b00, compat, "reset values");
        add_entry(K_MISC,  8'd16, w0, 32'd0, 2'b00, 64'(w0), "misc write");
        add_entry(K_MISC,  8'd16, w1, 32'd0, 2'b00, 64'(w1), "misc rewrite");
        add_entry(K_MISC,  8'd17, 32'hFFFF_FFFF, 32'd0, 2'b00, 64'(w1), "unused address 17");
        add_entry(K_MISC,  8'd0,  32'h1234_5678, 32'd0, 2'b00, 64'(w1), "unused address 0");
        add_entry(K_WRITE, 8'd40, 32'h0000_005A, 32'd0, 2'b00, 64'd0, "gpsdo status write");
        add_entry(K_RB,    8'd32, 32'd0, 32'd0, 2'b00, compat, "readback slot 0");
        add_entry(K_RB,    8'd32, 32'd1, m, 2'b11, 64'd0, "readback slot 1");
        add_entry(K_RB,    8'd32, 32'd2, m, 2'b00, {16'h0000, 8'h01, 8'h5A, m},
                  "readback slot 2");
        add_entry(K_RB,    8'd32, 32'd3, m, 2'b10, 64'd2, "readback slot 3, lock 10");
        add_entry(K_RB,    8'd32, 32'd3, m, 2'b01, 64'd1, "readback slot 3, lock 01");
        add_entry(K_WRITE, 8'd48, 32'd1, 32'd0, 2'b00, 64'd0, "select external pps");
        add_entry(K_PULSE, 8'd0,  32'd1, 32'd0, 2'b00, 64'd2, "external pps latency");
        add_entry(K_WRITE, 8'd48, 32'd0, 32'd0, 2'b00, 64'd0, "select gpsdo pps");
        add_entry(K_PULSE, 8'd0,  32'd0, 32'd0, 2'b00, 64'd2, "gpsdo pps latency");
        add_entry(K_WRITE, 8'd48, 32'd2, 32'd0, 2'b00, 64'd0, "select internal pps");
        add_entry(K_COUNT, 8'd0,  32'd0, 32'd0, 2'b00, 64'd10, "internal pps duty");
        add_entry(K_WRITE, 8'd48, 32'd3, 32'd0, 2'b00, 64'd0, "select no pps");
        add_entry(K_COUNT, 8'd0,  32'd0, 32'd0, 2'b00, 64'd0, "no pps stays low");
        add_entry(K_SYNC,  8'd48, 32'd6, 32'd0, 2'b00, 64'd1, "time-sync set");
        add_entry(K_COUNT, 8'd0,  32'd0, 32'd0, 2'b00, 64'd10, "pps select kept");
    endtask

    initial begin
        rb_data_t rb_before;
        logic     ts_before;
        int       lat;
        int       cnt;
        int       errs_before;
        int       passed;
        int       failed;
        passed       = 0;
        failed       = 0;
        bus_rst      = 1'b1;
        set_stb      = 1'b0;
        set_addr     = '0;
        set_data     = '0;
        rb_misc      = '0;
        lock_signals = 2'b00;
        pps_int      = 1'b0;
        pps_ext      = 1'b0;
        build_table();
        repeat (16) @(posedge radio_clk);
        bus_rst <= 1'b0;
        @(negedge radio_clk);

        //////////////////////////////////////////////////
        // table loop
        //////////////////////////////////////////////////
        for (int i = 0; i < n_entries; i++) begin
            errs_before = errors;
            case (kind[i])
                K_RESET: begin
                    check_word("o_misc_outs", 32'd0, misc_outs);
                    check_bit("o_time_sync", 1'b0, time_sync);
                    check_bit("o_pps", 1'b0, pps);
                    check_rb("o_rb_data", exp_val[i], rb_data);
                end
                K_WRITE: begin
                    bus_write(addr[i], data[i]);
                end
                K_MISC: begin
                    rb_before = rb_data;
                    ts_before = time_sync;
                    bus_write(addr[i], data[i]);
                    check_word("o_misc_outs", exp_val[i][31:0], misc_outs);
                    check_rb("o_rb_data", rb_before, rb_data);
                    check_bit("o_time_sync", ts_before, time_sync);
                end
                K_RB: begin
                    @(posedge radio_clk);
                    rb_misc      <= misc_in[i];
                    lock_signals <= lock_in[i];
                    bus_write(addr[i], data[i]);
                    // lock pair gets one extra cycle past its two flops
                    if (data[i][1:0] == 2'd3) begin
                        idle_cycles(1);
                    end
                    check_rb("o_rb_data", exp_val[i], rb_data);
                end
                K_SYNC: begin
                    bus_write(addr[i], data[i]);
                    check_bit("o_time_sync", exp_val[i][0], time_sync);
                end
                K_PULSE: begin
                    pulse_latency(data[i][0], lat);
                    check_word("o_pps latency", exp_val[i][31:0], set_data_t'(lat));
                end
                default: begin
                    count_high(cnt);
                    check_word("o_pps high count", exp_val[i][31:0], set_data_t'(cnt));
                end
            endcase
            if (errors == errs_before) begin
                passed++;
                $display("test %0d %s: passed", i, note[i]);
            end else begin
                failed++;
                $display("test %0d %s: FAILED", i, note[i]);
            end
        end

        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_core_control

//--- sim/core_control_assertions.sv
/*
 * Bound into core_control; watches misc and time-sync updates and the PPS mux.
 */
`timescale 1ns/10ps

module core_control_assertions (
    input logic                i_clk,
    input logic                i_rst,
    input logic                i_set_stb,
    input core_pkg::set_addr_t i_set_addr,
    input core_pkg::set_data_t i_set_data,
    input core_pkg::set_data_t i_misc_outs,
    input core_pkg::pps_sel_t  i_pps_sel,
    input logic                i_pps,
    input logic                i_time_sync
);

    import core_pkg::*;

    // misc loads the strobed word one cycle later
    misc_update: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_set_stb && i_set_addr == SR_CORE_MISC) |=> (i_misc_outs == $past(i_set_data)))
        else $error("misc output does not match the strobed data word");

    // time-sync only moves on a sync register write
    sync_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_set_stb && i_set_addr == SR_CORE_SYNC) |=> $stable(i_time_sync))
        else $error("time-sync changed without a sync register write");

    // select 3 for three cycles means no pulse
    pps_none: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_pps_sel == 2'd3 && $past(i_pps_sel) == 2'd3 && $past(i_pps_sel, 2) == 2'd3)
        |-> !i_pps)
        else $error("pps high with no source selected");

endmodule : core_control_assertions

bind core_control core_control_assertions core_control_assertions_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .i_misc_outs (o_misc_outs),
    .i_pps_sel   (pps_sel),
    .i_pps       (o_pps),
    .i_time_sync (o_time_sync)
);

//--- rtl/core_control.sv
/*
 * Settings and status core on a single clock, radio_clk with bus_rst.
 * PPS_PERIOD is the internal PPS period in clock cycles, positive and even.
 */
`timescale 1ns/10ps

module core_control #(
    parameter int PPS_PERIOD = 100_000_000
) (
    input  logic                i_clk,          // radio_clk
    input  logic                i_rst,          // bus_rst
    // settings bus
    input  logic                i_set_stb,
    input  core_pkg::set_addr_t i_set_addr,
    input  core_pkg::set_data_t i_set_data,
    // status inputs
    input  core_pkg::set_data_t i_rb_misc,
    input  logic [1:0]          i_lock_signals,
    // pps inputs
    input  logic                i_pps_int,
    input  logic                i_pps_ext,
    // outputs
    output core_pkg::set_data_t o_misc_outs,
    output core_pkg::rb_data_t  o_rb_data,
    output logic                o_pps,
    output logic                o_time_sync
);

    import core_pkg::*;

    rb_sel_t  rb_sel;
    status_t  gpsdo_st;
    pps_sel_t pps_sel;

    //////////////////////////////////////////////////
    // core registers
    //////////////////////////////////////////////////

    core_setting_regs core_setting_regs_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_set_stb   (i_set_stb),
        .i_set_addr  (i_set_addr),
        .i_set_data  (i_set_data),
        .o_misc_outs (o_misc_outs),
        .o_rb_sel    (rb_sel),
        .o_gpsdo_st  (gpsdo_st),
        .o_pps_sel   (pps_sel),
        .o_time_sync (o_time_sync)
    );

    //////////////////////////////////////////////////
    // pps and readback
    //////////////////////////////////////////////////

    pps_source #(
        .PPS_PERIOD (PPS_PERIOD)
    ) pps_source_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_pps_int (i_pps_int),
        .i_pps_ext (i_pps_ext),
        .i_pps_sel (pps_sel),
        .o_pps     (o_pps)
    );

    core_readback core_readback_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rb_sel       (rb_sel),
        .i_gpsdo_st     (gpsdo_st),
        .i_rb_misc      (i_rb_misc),
        .i_lock_signals (i_lock_signals),
        .o_rb_data      (o_rb_data)
    );

endmodule : core_control

//--- rtl/core_readback.sv
/*
 * Readback word, combinational from the select and status inputs.
 * Lock signals are async and take two flops before they show up in slot 3.
 */
`timescale 1ns/10ps

module core_readback (
    input  logic                i_clk,          // radio_clk
    input  logic                i_rst,          // bus_rst
    input  core_pkg::rb_sel_t   i_rb_sel,
    input  core_pkg::status_t   i_gpsdo_st,
    input  core_pkg::set_data_t i_rb_misc,
    input  logic [1:0]          i_lock_signals,
    output core_pkg::rb_data_t  o_rb_data
);

    import core_pkg::*;

    //////////////////////////////////////////////////
    // lock signal synchronizer
    //////////////////////////////////////////////////

    logic [1:0] lock_meta;
    logic [1:0] lock_sync;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
        end else begin
            lock_meta <= i_lock_signals;
            lock_sync <= lock_meta;
        end
    end

    //////////////////////////////////////////////////
    // readback mux
    //////////////////////////////////////////////////

    always_comb begin
        case (i_rb_sel)
            2'd0:    o_rb_data = {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            // spi readback slot, nothing behind it here
            2'd1:    o_rb_data = '0;
            2'd2:    o_rb_data = {16'h0000, RADIO_COUNT, i_gpsdo_st, i_rb_misc};
            default: o_rb_data = {62'd0, lock_sync};
        endcase
    end

endmodule : core_readback

//--- rtl/pps_source.sv
/*
 * PPS select: GPSDO, external or internal pulse, each through two flops.
 * PPS_PERIOD must be a positive even number of clock cycles.
 */
`timescale 1ns/10ps

module pps_source #(
    parameter int PPS_PERIOD = 100_000_000
) (
    input  logic               i_clk,       // radio_clk
    input  logic               i_rst,       // bus_rst
    input  logic               i_pps_int,   // gpsdo pulse
    input  logic               i_pps_ext,
    input  core_pkg::pps_sel_t i_pps_sel,
    output logic               o_pps
);

    localparam int CNT_W = (PPS_PERIOD > 1) ? $clog2(PPS_PERIOD) : 1;

    //////////////////////////////////////////////////
    // internal pps generator
    //////////////////////////////////////////////////

    logic [CNT_W-1:0] period_cnt;
    logic             gen_pps;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            period_cnt <= '0;
        end else if (period_cnt == CNT_W'(PPS_PERIOD - 1)) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // high for the first half of each period
    assign gen_pps = (period_cnt < CNT_W'(PPS_PERIOD / 2));

    //////////////////////////////////////////////////
    // synchronizers
    //////////////////////////////////////////////////

    // bit 0 gpsdo, bit 1 external, bit 2 internal
    logic [2:0] pps_meta;
    logic [2:0] pps_sync;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pps_meta <= '0;
            pps_sync <= '0;
        end else begin
            pps_meta <= {gen_pps, i_pps_ext, i_pps_int};
            pps_sync <= pps_meta;
        end
    end

    //////////////////////////////////////////////////
    // source mux
    //////////////////////////////////////////////////

    always_comb begin
        case (i_pps_sel)
            2'd0:    o_pps = pps_sync[0];
            2'd1:    o_pps = pps_sync[1];
            2'd2:    o_pps = pps_sync[2];
            // no source selected
            default: o_pps = 1'b0;
        endcase
    end

endmodule : pps_source

//--- rtl/core_setting_regs.sv
/*
 * Core registers on the settings bus; a write lands the cycle after the strobe.
 * Strobes to unknown addresses are ignored. GPSDO status has no reset value.
 */
`timescale 1ns/10ps

module core_setting_regs (
    input  logic                i_clk,       // radio_clk
    input  logic                i_rst,       // bus_rst
    input  logic                i_set_stb,
    input  core_pkg::set_addr_t i_set_addr,
    input  core_pkg::set_data_t i_set_data,
    output core_pkg::set_data_t o_misc_outs,
    output core_pkg::rb_sel_t   o_rb_sel,
    output core_pkg::status_t   o_gpsdo_st,
    output core_pkg::pps_sel_t  o_pps_sel,
    output logic                o_time_sync
);

    import core_pkg::*;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    logic hit_misc;
    logic hit_readback;
    logic hit_gpsdo_st;
    logic hit_sync;

    assign hit_misc     = i_set_stb && (i_set_addr == SR_CORE_MISC);
    assign hit_readback = i_set_stb && (i_set_addr == SR_CORE_READBACK);
    assign hit_gpsdo_st = i_set_stb && (i_set_addr == SR_CORE_GPSDO_ST);
    assign hit_sync     = i_set_stb && (i_set_addr == SR_CORE_SYNC);

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    set_data_t misc_q;
    rb_sel_t   rb_sel_q;
    status_t   gpsdo_st_q;
    // {time_sync, pps_sel}
    logic [2:0] sync_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            misc_q   <= '0;
            rb_sel_q <= '0;
            sync_q   <= '0;
        end else begin
            if (hit_misc) begin
                misc_q <= i_set_data;
            end
            if (hit_readback) begin
                rb_sel_q <= i_set_data[1:0];
            end
            if (hit_sync) begin
                sync_q <= i_set_data[2:0];
            end
        end
    end

    // gpsdo status byte, loaded by host software
    always_ff @(posedge i_clk) begin
        if (hit_gpsdo_st) begin
            gpsdo_st_q <= i_set_data[7:0];
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign o_misc_outs = misc_q;
    assign o_rb_sel    = rb_sel_q;
    assign o_gpsdo_st  = gpsdo_st_q;
    assign o_pps_sel   = sync_q[1:0];
    assign o_time_sync = sync_q[2];

endmodule : core_setting_regs

//--- rtl/core_pkg.sv
/*
 * Shared widths, register map and readback constants of the core.
 * One radio only, so RADIO_COUNT is fixed at 1.
 */
package core_pkg;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    // settings bus address
    typedef logic [7:0]  set_addr_t;
    // settings data word, also the misc output word
    typedef logic [31:0] set_data_t;
    // readback word as seen by the host
    typedef logic [63:0] rb_data_t;
    // readback slot select
    typedef logic [1:0]  rb_sel_t;
    // pps source code: 0 gpsdo, 1 external, 2 internal, 3 none
    typedef logic [1:0]  pps_sel_t;
    // status byte
    typedef logic [7:0]  status_t;

    //////////////////////////////////////////////////
    // register addresses
    //////////////////////////////////////////////////

    localparam set_addr_t SR_CORE_MISC     = 8'd16;
    localparam set_addr_t SR_CORE_READBACK = 8'd32;
    localparam set_addr_t SR_CORE_GPSDO_ST = 8'd40;
    // bits 1..0 pps select, bit 2 time-sync
    localparam set_addr_t SR_CORE_SYNC     = 8'd48;

    //////////////////////////////////////////////////
    // readback constants
    //////////////////////////////////////////////////

    // compat signature seen in slot 0
    localparam logic [31:0] COMPAT_SIGNATURE = 32'hACE0BA5E;
    localparam logic [15:0] COMPAT_MAJOR     = 16'h000E;
    localparam logic [15:0] COMPAT_MINOR     = 16'h0000;

    // number of radio channels in this build
    localparam status_t     RADIO_COUNT      = 8'd1;

endpackage : core_pkg
